/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_soc
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* compile.f */
src/soc_pkg.sv
src/bus_decoder.sv
src/misc_regs.sv
src/flash_select_seq.sv
src/scratch_ram.sv
src/soc_top.sv
testbench/soc_assertions.sv
testbench/tb_soc.sv

/* src/bus_decoder.sv */
// ------------------------------------------------------------
// bus decoder: picks a slave from the top address nibble and
// returns its read data and ready, or a bus error
// ------------------------------------------------------------

module bus_decoder
	import soc_pkg::*;
(
	input  logic      mem_valid_i,
	input  bus_addr_t mem_addr_i,
	input  bus_data_t misc_rdata_i,
	input  bus_data_t ram_rdata_i,
	input  logic      ram_ready_i,

	output logic      misc_sel_o,
	output logic      ram_sel_o,
	output bus_data_t mem_rdata_o,
	output logic      mem_ready_o,
	output logic      bus_error_o
);

	region_t region;

	assign region = mem_addr_i[31:28];

	always_comb begin
		misc_sel_o  = 1'b0;
		ram_sel_o   = 1'b0;
		bus_error_o = 1'b0;
		mem_rdata_o = '0;
		mem_ready_o = 1'b0;

		case (region)
			REGION_MISC: begin
				// register block answers in the same cycle
				misc_sel_o  = mem_valid_i;
				mem_rdata_o = misc_rdata_i;
				mem_ready_o = mem_valid_i;
			end
			REGION_RAM: begin
				ram_sel_o   = mem_valid_i;
				mem_rdata_o = ram_rdata_i;
				// one wait state, ready comes from the ram itself
				mem_ready_o = ram_ready_i;
			end
			default: begin
				// nothing mapped here, finish at once and flag it
				mem_rdata_o = BUS_ERROR_DATA;
				mem_ready_o = mem_valid_i;
				bus_error_o = mem_valid_i;
			end
		endcase
	end

endmodule

/* src/flash_select_seq.sv */
// ------------------------------------------------------------
// flash select sequencer: delayed clock pulse for the select
// flip-flop and the FPGA reload at the end of the countdown
// ------------------------------------------------------------

module flash_select_seq
	import soc_pkg::*;
(
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe_i,
	input  logic reload_req_i,
	output logic fsel_c_o,
	output logic programn_o
);

	logic [2:0] delay_q;
	logic       reload_queued_q;
	logic       reload_fired_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			delay_q         <= '0;
			reload_queued_q <= 1'b0;
			reload_fired_q  <= 1'b0;
		end else if (fsel_strobe_i) begin
			delay_q         <= FSEL_DELAY_LOAD;
			reload_queued_q <= reload_req_i;
		end else if (delay_q != 3'd0) begin
			delay_q <= delay_q - 3'd1;
			// select d-ff has been clocked by now, safe to reload
			if (delay_q == 3'd1 && reload_queued_q) begin
				reload_fired_q <= 1'b1;
			end
		end
	end

	// three cycle clock pulse in the middle of the countdown
	assign fsel_c_o   = (delay_q == 3'd5) || (delay_q == 3'd4) || (delay_q == 3'd3);
	assign programn_o = ~reload_fired_q;

endmodule

/* src/misc_regs.sv */
// ------------------------------------------------------------
// misc register block: LEDs, buttons, version and trace,
// general I/O bank and the flash select register
// ------------------------------------------------------------

module misc_regs
	import soc_pkg::*;
#(
	parameter int        GENIO_WIDTH = 30,
	parameter bus_data_t SOC_VERSION = '0
) (
	input  logic                   clk48m,
	input  logic                   rst,

	input  logic                   misc_sel_i,
	input  bus_addr_t              mem_addr_i,
	input  bus_data_t              mem_wdata_i,
	input  bus_strb_t              mem_wstrb_i,

	input  btn_t                   btn_i,
	input  logic [GENIO_WIDTH-1:0] genio_in_i,

	output bus_data_t              misc_rdata_o,
	output led_t                   led_o,
	output logic [GENIO_WIDTH-1:0] genio_out_o,
	output logic [GENIO_WIDTH-1:0] genio_oe_o,
	output logic                   fsel_d_o,
	output logic                   trace_en_o,
	output logic                   fsel_strobe_o,
	output logic                   reload_req_o
);

	misc_idx_t              idx;
	logic                   wr_en;
	logic [15:0]            led_q;
	logic [GENIO_WIDTH-1:0] genio_out_q;
	logic [GENIO_WIDTH-1:0] genio_oe_q;
	logic [GENIO_WIDTH-1:0] genio_wdata;
	logic                   trace_en_q;
	logic                   fsel_d_q;
	logic                   fsel_strobe_q;
	logic                   reload_req_q;

	assign idx         = mem_addr_i[6:2];
	// only the low byte lane counts as a register write
	assign wr_en       = misc_sel_i & mem_wstrb_i[0];
	assign genio_wdata = mem_wdata_i[GENIO_WIDTH-1:0];

	// ------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q         <= '0;
			genio_out_q   <= '0;
			genio_oe_q    <= '0;
			trace_en_q    <= 1'b0;
			fsel_d_q      <= 1'b0;
			fsel_strobe_q <= 1'b0;
			reload_req_q  <= 1'b0;
		end else begin
			// strobe and reload request are single cycle pulses
			fsel_strobe_q <= 1'b0;
			reload_req_q  <= 1'b0;
			if (wr_en) begin
				case (idx)
					MISC_REG_LED:       led_q <= mem_wdata_i[15:0];
					MISC_REG_SOC_VER:   trace_en_q <= mem_wdata_i[0];
					MISC_REG_GENIO_OUT: genio_out_q <= genio_wdata;
					MISC_REG_GENIO_OE:  genio_oe_q <= genio_wdata;
					MISC_REG_GENIO_W2S: genio_out_q <= genio_out_q | genio_wdata;
					MISC_REG_GENIO_W2C: genio_out_q <= genio_out_q & ~genio_wdata;
					MISC_REG_FLASH_SEL: begin
						fsel_d_q      <= mem_wdata_i[0];
						fsel_strobe_q <= 1'b1;
						// reload only with the key in the upper bits
						reload_req_q  <= (mem_wdata_i[31:8] == RELOAD_KEY);
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------
	always_comb begin
		misc_rdata_o = '0;
		case (idx)
			MISC_REG_LED:       misc_rdata_o = {16'h0, led_q};
			// buttons are active low on the board
			MISC_REG_BTN:       misc_rdata_o = {24'h0, ~btn_i};
			MISC_REG_SOC_VER:   misc_rdata_o = SOC_VERSION;
			MISC_REG_FLASH_SEL: misc_rdata_o = {31'h0, fsel_d_q};
			MISC_REG_GENIO_IN:  misc_rdata_o[GENIO_WIDTH-1:0] = genio_in_i;
			MISC_REG_GENIO_OUT: misc_rdata_o[GENIO_WIDTH-1:0] = genio_out_q;
			MISC_REG_GENIO_OE:  misc_rdata_o[GENIO_WIDTH-1:0] = genio_oe_q;
			default:            misc_rdata_o = '0;
		endcase
	end

	// led pins skip bits 7..6 of the register
	assign led_o         = {led_q[10:8], led_q[5:0]};
	assign genio_out_o   = genio_out_q;
	assign genio_oe_o    = genio_oe_q;
	assign fsel_d_o      = fsel_d_q;
	assign trace_en_o    = trace_en_q;
	assign fsel_strobe_o = fsel_strobe_q;
	assign reload_req_o  = reload_req_q;

endmodule

/* src/scratch_ram.sv */
// ------------------------------------------------------------
// scratch ram: word memory with byte strobes, one wait state
// ------------------------------------------------------------

module scratch_ram
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 256
) (
	input  logic      clk48m,
	input  logic      rst,
	input  logic      ram_sel_i,
	input  bus_addr_t mem_addr_i,
	input  bus_data_t mem_wdata_i,
	input  bus_strb_t mem_wstrb_i,
	output bus_data_t ram_rdata_o,
	output logic      ram_ready_o
);

	localparam int IDX_W = $clog2(RAM_WORDS);

	bus_data_t        mem [RAM_WORDS];
	logic [IDX_W-1:0] word_idx;
	logic             access;
	logic             ready_q;

	assign word_idx = IDX_W'(mem_addr_i[31:2] % RAM_WORDS);
	// accept only on the first selected cycle
	assign access   = ram_sel_i & ~ready_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	always_ff @(posedge clk48m) begin
		if (access) begin
			ram_rdata_o <= mem[word_idx];
			for (int b = 0; b < 4; b++) begin
				if (mem_wstrb_i[b]) begin
					mem[word_idx][8*b +: 8] <= mem_wdata_i[8*b +: 8];
				end
			end
		end
	end

	assign ram_ready_o = ready_q;

endmodule

/* src/soc_pkg.sv */
// ------------------------------------------------------------
// soc package: bus types, region codes, misc register indices
// and the magic values shared by the peripheral side
// ------------------------------------------------------------

package soc_pkg;

	// ------------------------------------------------------------
	// bus types
	// ------------------------------------------------------------

	// byte address as presented by the bus master
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// all zero means a read
	typedef logic [3:0]  bus_strb_t;

	// top address nibble
	typedef logic [3:0]  region_t;
	// word index inside the misc region, address bits 6..2
	typedef logic [4:0]  misc_idx_t;

	typedef logic [8:0]  led_t;
	typedef logic [7:0]  btn_t;

	// ------------------------------------------------------------
	// address map
	// ------------------------------------------------------------
	localparam region_t REGION_MISC = 4'h2;
	localparam region_t REGION_RAM  = 4'h4;

	localparam misc_idx_t MISC_REG_LED       = 5'd0;
	localparam misc_idx_t MISC_REG_BTN       = 5'd1;
	localparam misc_idx_t MISC_REG_SOC_VER   = 5'd2;
	localparam misc_idx_t MISC_REG_FLASH_SEL = 5'd13;
	localparam misc_idx_t MISC_REG_GENIO_IN  = 5'd17;
	localparam misc_idx_t MISC_REG_GENIO_OUT = 5'd18;
	localparam misc_idx_t MISC_REG_GENIO_OE  = 5'd19;
	localparam misc_idx_t MISC_REG_GENIO_W2S = 5'd20;
	localparam misc_idx_t MISC_REG_GENIO_W2C = 5'd21;

	// ------------------------------------------------------------
	// magic values
	// ------------------------------------------------------------
	localparam bus_data_t BUS_ERROR_DATA = 32'hDEADBEEF;

	// upper 24 bits of a FLASH_SEL write that request an FPGA reload
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// start value of the flash select delay counter
	localparam logic [2:0] FSEL_DELAY_LOAD = 3'd7;

endpackage

/* src/soc_top.sv */
// ------------------------------------------------------------
// soc top: peripheral side of the bus, decoder plus slaves
// ------------------------------------------------------------

module soc_top
	import soc_pkg::*;
#(
	parameter int        GENIO_WIDTH = 30,
	parameter bus_data_t SOC_VERSION = '0,
	parameter int        RAM_WORDS   = 256
) (
	input  logic                   clk48m,
	input  logic                   rst,

	input  logic                   mem_valid_i,
	input  bus_addr_t              mem_addr_i,
	input  bus_data_t              mem_wdata_i,
	input  bus_strb_t              mem_wstrb_i,
	output bus_data_t              mem_rdata_o,
	output logic                   mem_ready_o,
	output logic                   bus_error_o,

	input  btn_t                   btn_i,
	input  logic [GENIO_WIDTH-1:0] genio_in_i,
	output led_t                   led_o,
	output logic [GENIO_WIDTH-1:0] genio_out_o,
	output logic [GENIO_WIDTH-1:0] genio_oe_o,

	output logic                   fsel_d_o,
	output logic                   fsel_c_o,
	output logic                   programn_o,
	output logic                   trace_en_o
);

	logic      misc_sel;
	logic      ram_sel;
	bus_data_t misc_rdata;
	bus_data_t ram_rdata;
	logic      ram_ready;
	logic      fsel_strobe;
	logic      reload_req;

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	bus_decoder decoder (
		.mem_valid_i  (mem_valid_i),
		.mem_addr_i   (mem_addr_i),
		.misc_rdata_i (misc_rdata),
		.ram_rdata_i  (ram_rdata),
		.ram_ready_i  (ram_ready),
		.misc_sel_o   (misc_sel),
		.ram_sel_o    (ram_sel),
		.mem_rdata_o  (mem_rdata_o),
		.mem_ready_o  (mem_ready_o),
		.bus_error_o  (bus_error_o)
	);

	// ------------------------------------------------------------
	// slaves
	// ------------------------------------------------------------
	misc_regs #(
		.GENIO_WIDTH (GENIO_WIDTH),
		.SOC_VERSION (SOC_VERSION)
	) misc (
		.clk48m        (clk48m),
		.rst           (rst),
		.misc_sel_i    (misc_sel),
		.mem_addr_i    (mem_addr_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_wstrb_i   (mem_wstrb_i),
		.btn_i         (btn_i),
		.genio_in_i    (genio_in_i),
		.misc_rdata_o  (misc_rdata),
		.led_o         (led_o),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.fsel_d_o      (fsel_d_o),
		.trace_en_o    (trace_en_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_req_o  (reload_req)
	);

	flash_select_seq fsel_seq (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_req_i  (reload_req),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) ram (
		.clk48m      (clk48m),
		.rst         (rst),
		.ram_sel_i   (ram_sel),
		.mem_addr_i  (mem_addr_i),
		.mem_wdata_i (mem_wdata_i),
		.mem_wstrb_i (mem_wstrb_i),
		.ram_rdata_o (ram_rdata),
		.ram_ready_o (ram_ready)
	);

endmodule

/* testbench/soc_assertions.sv */
// ------------------------------------------------------------
// bus and flash select protocol checks, bound to soc_top
// ------------------------------------------------------------

module soc_assertions (
	input logic clk48m,
	input logic rst,
	input logic mem_valid_i,
	input logic mem_ready_o,
	input logic bus_error_o,
	input logic fsel_c_o,
	input logic programn_o
);

	// a slave only answers a presented transfer
	ready_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		mem_ready_o |-> mem_valid_i)
		else $error("mem_ready_o high without mem_valid_i");

	error_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		bus_error_o |-> mem_valid_i)
		else $error("bus_error_o high without mem_valid_i");

	// clock pulse is at most three cycles wide
	fsel_pulse_width: assert property (@(posedge clk48m) disable iff (rst)
		(fsel_c_o && $past(fsel_c_o) && $past(fsel_c_o, 2)) |-> !$past(fsel_c_o, 3))
		else $error("fsel_c_o high for more than 3 cycles");

	programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn_o |=> !programn_o)
		else $error("programn_o rose again without reset");

endmodule

bind soc_top soc_assertions assertions_i (
	.clk48m      (clk48m),
	.rst         (rst),
	.mem_valid_i (mem_valid_i),
	.mem_ready_o (mem_ready_o),
	.bus_error_o (bus_error_o),
	.fsel_c_o    (fsel_c_o),
	.programn_o  (programn_o)
);

/* testbench/tb_soc.sv */
// ------------------------------------------------------------
// soc testbench with a bus master and directed register,
// ram and flash select tests
// ------------------------------------------------------------

module tb_soc
	import soc_pkg::*;
();

	localparam int        GENIO_W = 30;
	localparam bus_data_t SOC_VER = 32'h0001_0203;
	localparam int        TIMEOUT = 20;

	logic               clk48m = 1'b0;
	logic               rst;
	logic               mem_valid;
	bus_addr_t          mem_addr;
	bus_data_t          mem_wdata;
	bus_strb_t          mem_wstrb;
	bus_data_t          mem_rdata;
	logic               mem_ready;
	logic               bus_error;
	btn_t               btn;
	logic [GENIO_W-1:0] genio_in;
	led_t               led;
	logic [GENIO_W-1:0] genio_out;
	logic [GENIO_W-1:0] genio_oe;
	logic               fsel_d;
	logic               fsel_c;
	logic               programn;
	logic               trace_en;

	logic [31:0] lfsr = 32'h4573;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          last_wait;

	soc_top #(
		.GENIO_WIDTH (GENIO_W),
		.SOC_VERSION (SOC_VER),
		.RAM_WORDS   (256)
	) dut_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.mem_valid_i (mem_valid),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_wstrb_i (mem_wstrb),
		.mem_rdata_o (mem_rdata),
		.mem_ready_o (mem_ready),
		.bus_error_o (bus_error),
		.btn_i       (btn),
		.genio_in_i  (genio_in),
		.led_o       (led),
		.genio_out_o (genio_out),
		.genio_oe_o  (genio_oe),
		.fsel_d_o    (fsel_d),
		.fsel_c_o    (fsel_c),
		.programn_o  (programn),
		.trace_en_o  (trace_en)
	);

	always #50 clk48m = ~clk48m;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	// galois lfsr stepped once per bit taken
	function automatic bus_data_t rand_bits(input int nbits);
		bus_data_t v;
		logic      lsb;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 32'h8020_0003;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	function automatic bus_addr_t misc_addr(input misc_idx_t idx);
		return {4'h2, 21'h0, idx, 2'b00};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$finish;
	endtask

	task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_led(input string what, input led_t got, input led_t exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

	// ------------------------------------------------------------
	// bus master tasks start on a rising edge
	// ------------------------------------------------------------
	task automatic wait_ready(input string who);
		last_wait = 0;
		do begin
			@(posedge clk48m);
			last_wait++;
		end while (!mem_ready && last_wait < TIMEOUT);
		if (!mem_ready) begin
			abort_run({who, " timed out waiting for mem_ready_o"});
		end
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input bus_strb_t strb);
		mem_valid <= 1'b1;
		mem_addr  <= addr;
		mem_wdata <= data;
		mem_wstrb <= strb;
		wait_ready("bus_write");
		mem_valid <= 1'b0;
		mem_wstrb <= '0;
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output logic err);
		mem_valid <= 1'b1;
		mem_addr  <= addr;
		mem_wstrb <= '0;
		wait_ready("bus_read");
		data = mem_rdata;
		err  = bus_error;
		mem_valid <= 1'b0;
	endtask

	task automatic verify_genio_out(input string what, input bus_data_t model);
		bus_data_t rd;
		logic      err;
		bus_read(misc_addr(MISC_REG_GENIO_OUT), rd, err);
		check_data({what, " readback"}, rd, model);
		check_data({what, " on genio_out_o"}, bus_data_t'(genio_out), model);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_genio();
		bus_data_t model;
		bus_data_t mask;
		bus_data_t rd;
		logic      err;
		model = rand_bits(GENIO_W);
		bus_write(misc_addr(MISC_REG_GENIO_OUT), model, 4'hF);
		verify_genio_out("genio out", model);
		mask = rand_bits(GENIO_W);
		bus_write(misc_addr(MISC_REG_GENIO_W2S), mask, 4'hF);
		model = model | mask;
		verify_genio_out("genio w2s", model);
		mask = rand_bits(GENIO_W);
		bus_write(misc_addr(MISC_REG_GENIO_W2C), mask, 4'hF);
		model = model & ~mask;
		verify_genio_out("genio w2c", model);
		mask = rand_bits(GENIO_W);
		bus_write(misc_addr(MISC_REG_GENIO_OE), mask, 4'hF);
		bus_read(misc_addr(MISC_REG_GENIO_OE), rd, err);
		check_data("genio oe readback", rd, mask);
		check_data("genio_oe_o", bus_data_t'(genio_oe), mask);
		mask = rand_bits(GENIO_W);
		genio_in <= mask[GENIO_W-1:0];
		bus_read(misc_addr(MISC_REG_GENIO_IN), rd, err);
		check_data("genio in readback", rd, mask);
	endtask

	task automatic test_led_btn();
		bus_data_t w;
		bus_data_t rd;
		logic      err;
		btn_t      b;
		w = rand_bits(16);
		bus_write(misc_addr(MISC_REG_LED), w, 4'hF);
		bus_read(misc_addr(MISC_REG_LED), rd, err);
		check_data("led readback", rd, {16'h0, w[15:0]});
		// pins take led bits 10..8 and 5..0
		check_led("led_o", led, {w[10:8], w[5:0]});
		w = rand_bits(8);
		b = w[7:0];
		btn <= b;
		bus_read(misc_addr(MISC_REG_BTN), rd, err);
		check_data("button readback", rd, {24'h0, ~b});
	endtask

	task automatic test_ram();
		bus_addr_t addr;
		bus_data_t full;
		bus_data_t part;
		bus_data_t exp;
		bus_data_t rd;
		bus_strb_t strb;
		logic      err;
		full = rand_bits(8);
		addr = {4'h4, 18'h0, full[7:0], 2'b00};
		full = rand_bits(32);
		bus_write(addr, full, 4'hF);
		check_bit("ram write ready after one wait state", last_wait == 2, 1'b1);
		part = rand_bits(4);
		strb = part[3:0];
		// an all zero strobe would turn the write into a read
		if (strb == '0) begin
			strb = 4'b0101;
		end
		part = rand_bits(32);
		bus_write(addr, part, strb);
		for (int b = 0; b < 4; b++) begin
			exp[8*b +: 8] = strb[b] ? part[8*b +: 8] : full[8*b +: 8];
		end
		bus_read(addr, rd, err);
		check_data("ram merged word", rd, exp);
		check_bit("bus_error_o on ram read", err, 1'b0);
	endtask

	task automatic test_bus_error();
		bus_data_t rd;
		logic      err;
		bus_read(32'h0000_0100, rd, err);
		check_data("unmapped read data", rd, 32'hDEAD_BEEF);
		check_bit("bus_error_o on unmapped read", err, 1'b1);
		check_bit("unmapped ready in same cycle", last_wait == 1, 1'b1);
		bus_read(misc_addr(5'd5), rd, err);
		check_data("unused misc index 5", rd, '0);
		check_bit("bus_error_o in misc region", err, 1'b0);
	endtask

	task automatic test_flash_sel();
		int        n;
		int        hi;
		bus_data_t rd;
		logic      err;
		check_bit("programn_o after reset", programn, 1'b1);
		bus_write(misc_addr(MISC_REG_FLASH_SEL), 32'h0000_0001, 4'hF);
		n = 0;
		do begin
			@(posedge clk48m);
			n++;
		end while (!fsel_c && n < TIMEOUT);
		if (!fsel_c) begin
			abort_run("fsel_c_o never rose after the flash select write");
		end else begin
			hi = 0;
			while (fsel_c && hi < TIMEOUT) begin
				hi++;
				@(posedge clk48m);
			end
			check_data("fsel_c_o pulse length", bus_data_t'(hi), 32'd3);
		end
		check_bit("fsel_d_o", fsel_d, 1'b1);
		bus_read(misc_addr(MISC_REG_FLASH_SEL), rd, err);
		check_data("flash select readback", rd, 32'd1);
		// countdown has run out by now and must not reload without the key
		repeat (4) @(posedge clk48m);
		check_bit("programn_o without key", programn, 1'b1);
		bus_write(misc_addr(MISC_REG_FLASH_SEL), {24'hD0F1A5, 8'h01}, 4'hF);
		n = 0;
		do begin
			@(posedge clk48m);
			n++;
		end while (programn && n < TIMEOUT);
		if (programn) begin
			abort_run("programn_o did not fall after the keyed reload write");
		end
	endtask

	task automatic test_version();
		bus_data_t rd;
		logic      err;
		check_bit("trace_en_o after reset", trace_en, 1'b0);
		bus_read(misc_addr(MISC_REG_SOC_VER), rd, err);
		check_data("soc version", rd, SOC_VER);
		bus_write(misc_addr(MISC_REG_SOC_VER), 32'h0000_0001, 4'hF);
		bus_read(misc_addr(MISC_REG_SOC_VER), rd, err);
		check_data("soc version after write", rd, SOC_VER);
		check_bit("trace_en_o", trace_en, 1'b1);
	endtask

	initial begin
		rst       = 1'b1;
		mem_valid = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		btn       = '0;
		genio_in  = '0;
		repeat (3) @(posedge clk48m);
		rst <= 1'b0;

		test_genio();
		end_test("general io");
		test_led_btn();
		end_test("led and buttons");
		test_ram();
		end_test("scratch ram");
		test_bus_error();
		end_test("bus error");
		test_version();
		end_test("version and trace");
		test_flash_sel();
		end_test("flash select");

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
